//--- rtl/softermax_cfg.svh
// Softermax window configuration
`ifndef SOFTERMAX_CFG_SVH
`define SOFTERMAX_CFG_SVH

// Scores in one local window
`define SM_PARALLELISM 4

// Input score format, signed Q4.4
`define SM_IN_WIDTH 8
`define SM_IN_FRAC 4

// Power-of-two result format, unsigned Q1.7
`define SM_OUT_WIDTH 8
`define SM_OUT_FRAC 7

// Score FIFO holds whole windows while the max is found
`define SM_INPUT_FIFO_DEPTH 16

// Max FIFO covers the subtract and pow2 stages
`define SM_MAX_FIFO_DEPTH 8

`endif

//--- rtl/softermax_pkg.sv
// Softermax shared types
`include "softermax_cfg.svh"

package softermax_pkg;

  // Signed fixed-point input score
  typedef logic signed [`SM_IN_WIDTH-1:0] sm_score_t;

  // Integer part of a score after floor rounding
  typedef logic signed [`SM_IN_WIDTH-`SM_IN_FRAC-1:0] sm_int_t;

  // Score minus integer max, one extra bit of headroom
  typedef logic signed [`SM_IN_WIDTH:0] sm_diff_t;

  // Approximate power of two, unsigned
  typedef logic [`SM_OUT_WIDTH-1:0] sm_pow_t;

endpackage

//--- rtl/skid_buffer.sv
// Valid/ready skid buffer
module skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic [WIDTH-1:0] main_data;
  logic [WIDTH-1:0] skid_data;
  logic             main_valid;
  logic             skid_valid;
  logic             main_free;

  // Main register can take a word this cycle
  assign main_free = out_ready || !main_valid;

  // Ready comes straight from a flop
  assign in_ready  = !skid_valid;
  assign out_data  = main_data;
  assign out_valid = main_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= in_valid;
      end
    end else if (in_valid && in_ready) begin
      // Output stalled, park the incoming word
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (in_valid) begin
        main_data <= in_data;
      end
    end else if (in_valid && in_ready) begin
      skid_data <= in_data;
    end
  end

endmodule

//--- rtl/stream_fifo.sv
// Valid/ready circular FIFO
module stream_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_write;
  logic             do_read;

  // Full only blocks the writer
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign do_write = in_valid && in_ready;
  assign do_read  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves the count unchanged
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

//--- rtl/max_tree.sv
// Pipelined signed maximum tree
`include "softermax_cfg.svh"

module max_tree
  import softermax_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  sm_int_t in_data [`SM_PARALLELISM],
  input  logic    in_valid,
  output logic    in_ready,
  output sm_int_t out_data,
  output logic    out_valid,
  input  logic    out_ready
);

  // First level reduces lane pairs
  localparam int PAIRS = `SM_PARALLELISM / 2;

  sm_int_t lvl1_data [PAIRS];
  logic    lvl1_valid;
  logic    advance;

  function automatic sm_int_t max2(input sm_int_t a, input sm_int_t b);
    max2 = (a > b) ? a : b;
  endfunction

  // Whole tree moves together unless the output is held
  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;

  always_ff @(posedge clk) begin
    if (reset) begin
      lvl1_valid <= 1'b0;
      out_valid  <= 1'b0;
    end else if (advance) begin
      lvl1_valid <= in_valid;
      out_valid  <= lvl1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < PAIRS; i++) begin
        lvl1_data[i] <= max2(in_data[2*i], in_data[2*i+1]);
      end
      // Second level closes the tree for four lanes
      out_data <= max2(lvl1_data[0], lvl1_data[1]);
    end
  end

endmodule

//--- rtl/lpw_pow2.sv
// Linear piecewise power of two
`include "softermax_cfg.svh"

module lpw_pow2
  import softermax_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  sm_diff_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output sm_pow_t  out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // Integer field of the difference, sign included
  localparam int INT_W = `SM_IN_WIDTH - `SM_IN_FRAC + 1;
  // Moves the mantissa fraction up to the output fraction
  localparam int SCALE = `SM_OUT_FRAC - `SM_IN_FRAC;

  logic signed [INT_W-1:0] int_part;
  logic [INT_W-1:0]        shift_in;
  logic [`SM_IN_FRAC:0]    mant_in;
  logic [INT_W-1:0]        s1_shift;
  logic [`SM_IN_FRAC:0]    s1_mant;
  logic                    s1_valid;
  sm_pow_t                 scaled;
  logic                    advance;

  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;

  // d = -n + f, so n is minus the floor of d
  assign int_part = in_data[`SM_IN_WIDTH:`SM_IN_FRAC];
  assign shift_in = -int_part;
  // 1 + f
  assign mant_in  = {1'b1, in_data[`SM_IN_FRAC-1:0]};

  assign scaled = sm_pow_t'(s1_mant) << SCALE;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else if (advance) begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_shift <= shift_in;
      s1_mant  <= mant_in;
      // Everything shifts out once n reaches the output width
      if (s1_shift >= `SM_OUT_WIDTH) begin
        out_data <= '0;
      end else begin
        out_data <= scaled >> s1_shift;
      end
    end
  end

endmodule

//--- rtl/softermax_local_window.sv
// Softermax local window max and pow2
`include "softermax_cfg.svh"

module softermax_local_window
  import softermax_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  sm_score_t in_data [`SM_PARALLELISM],
  input  logic      in_valid,
  output logic      in_ready,
  output sm_pow_t   out_values [`SM_PARALLELISM],
  output sm_int_t   out_max,
  output logic      out_valid,
  input  logic      out_ready
);

  localparam int P       = `SM_PARALLELISM;
  localparam int SCORE_W = $bits(sm_score_t);
  localparam int INT_W   = $bits(sm_int_t);
  localparam int DIFF_W  = $bits(sm_diff_t);

  // Floor rounding and max tree
  sm_int_t  round_in_data [P];
  sm_int_t  round_out_data [P];
  logic     round_in_valid;
  logic [P-1:0] round_in_ready;
  logic [P-1:0] round_out_valid;
  logic     round_out_ready;
  sm_int_t  max_data;
  logic     max_valid;
  logic     max_ready;

  // Score window FIFO, one flat word per window
  logic [P*SCORE_W-1:0] score_fifo_in_data;
  logic [P*SCORE_W-1:0] score_fifo_out_data;
  logic     score_fifo_in_valid;
  logic     score_fifo_in_ready;
  logic     score_fifo_out_valid;
  logic     score_fifo_out_ready;

  // Max copies for subtract and output
  sm_int_t  sub_max_out_data;
  logic     sub_max_in_valid;
  logic     sub_max_in_ready;
  logic     sub_max_out_valid;
  logic     sub_max_out_ready;
  sm_int_t  max_fifo_out_data;
  logic     max_fifo_in_valid;
  logic     max_fifo_in_ready;
  logic     max_fifo_out_valid;
  logic     max_fifo_out_ready;

  // Subtract and pow2 lanes
  sm_score_t max_fixed;
  sm_diff_t  diff_data [P];
  sm_diff_t  diff_out_data [P];
  logic      sub_in_valid;
  logic [P-1:0] sub_in_ready;
  logic [P-1:0] diff_out_valid;
  logic [P-1:0] diff_out_ready;
  sm_pow_t   pow_data [P];
  logic [P-1:0] pow_valid;
  logic      pow_ready;

  // Lanes run in lock step, so the reductions only merge equal bits

  // Input split
  assign in_ready            = (&round_in_ready) && score_fifo_in_ready;
  assign round_in_valid      = in_valid && score_fifo_in_ready;
  assign score_fifo_in_valid = in_valid && (&round_in_ready);

  for (genvar i = 0; i < P; i++) begin : g_round
    // Dropping the fraction bits floors a two's complement value
    assign round_in_data[i] = in_data[i][SCORE_W-1:`SM_IN_FRAC];
    assign score_fifo_in_data[i*SCORE_W +: SCORE_W] = in_data[i];

    skid_buffer #(.WIDTH(INT_W)) round_skid_inst (
      .clk       (clk),
      .reset     (reset),
      .in_data   (round_in_data[i]),
      .in_valid  (round_in_valid),
      .in_ready  (round_in_ready[i]),
      .out_data  (round_out_data[i]),
      .out_valid (round_out_valid[i]),
      .out_ready (round_out_ready)
    );
  end

  max_tree max_tree_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (round_out_data),
    .in_valid  (&round_out_valid),
    .in_ready  (round_out_ready),
    .out_data  (max_data),
    .out_valid (max_valid),
    .out_ready (max_ready)
  );

  stream_fifo #(.WIDTH(P*SCORE_W), .DEPTH(`SM_INPUT_FIFO_DEPTH)) score_fifo_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (score_fifo_in_data),
    .in_valid  (score_fifo_in_valid),
    .in_ready  (score_fifo_in_ready),
    .out_data  (score_fifo_out_data),
    .out_valid (score_fifo_out_valid),
    .out_ready (score_fifo_out_ready)
  );

  // Max split
  assign max_ready         = sub_max_in_ready && max_fifo_in_ready;
  assign sub_max_in_valid  = max_valid && max_fifo_in_ready;
  assign max_fifo_in_valid = max_valid && sub_max_in_ready;

  skid_buffer #(.WIDTH(INT_W)) sub_max_skid_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (max_data),
    .in_valid  (sub_max_in_valid),
    .in_ready  (sub_max_in_ready),
    .out_data  (sub_max_out_data),
    .out_valid (sub_max_out_valid),
    .out_ready (sub_max_out_ready)
  );

  stream_fifo #(.WIDTH(INT_W), .DEPTH(`SM_MAX_FIFO_DEPTH)) max_fifo_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (max_data),
    .in_valid  (max_fifo_in_valid),
    .in_ready  (max_fifo_in_ready),
    .out_data  (max_fifo_out_data),
    .out_valid (max_fifo_out_valid),
    .out_ready (max_fifo_out_ready)
  );

  // Subtract join
  assign sub_in_valid         = sub_max_out_valid && score_fifo_out_valid;
  assign sub_max_out_ready    = (&sub_in_ready) && score_fifo_out_valid;
  assign score_fifo_out_ready = (&sub_in_ready) && sub_max_out_valid;

  // Integer max with zero fraction bits
  assign max_fixed = {sub_max_out_data, {`SM_IN_FRAC{1'b0}}};

  for (genvar i = 0; i < P; i++) begin : g_lane
    assign diff_data[i] = sm_diff_t'(sm_score_t'(score_fifo_out_data[i*SCORE_W +: SCORE_W]))
                        - sm_diff_t'(max_fixed);

    skid_buffer #(.WIDTH(DIFF_W)) diff_skid_inst (
      .clk       (clk),
      .reset     (reset),
      .in_data   (diff_data[i]),
      .in_valid  (sub_in_valid),
      .in_ready  (sub_in_ready[i]),
      .out_data  (diff_out_data[i]),
      .out_valid (diff_out_valid[i]),
      .out_ready (diff_out_ready[i])
    );

    lpw_pow2 lpw_pow2_inst (
      .clk       (clk),
      .reset     (reset),
      .in_data   (diff_out_data[i]),
      .in_valid  (diff_out_valid[i]),
      .in_ready  (diff_out_ready[i]),
      .out_data  (pow_data[i]),
      .out_valid (pow_valid[i]),
      .out_ready (pow_ready)
    );
  end

  // Output join
  assign out_valid          = (&pow_valid) && max_fifo_out_valid;
  assign pow_ready          = out_ready && max_fifo_out_valid;
  assign max_fifo_out_ready = out_ready && (&pow_valid);

  assign out_values = pow_data;
  assign out_max    = max_fifo_out_data;

endmodule

//--- bench/softermax_tb.sv
// Softermax local window testbench
`include "softermax_cfg.svh"

module softermax_tb
  import softermax_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int P = `SM_PARALLELISM;
  localparam int SW = $bits(sm_score_t);
  localparam int OW = $bits(sm_pow_t);
  localparam int WAIT_LIMIT = 2000;
  localparam int RANDOM_WINDOWS = 40;
  localparam int STALL_LIMIT = 64;
  localparam logic [31:0] SEED = 32'h8b1eb9d0;

  localparam int READY_HIGH = 0;
  localparam int READY_LOW = 1;
  localparam int READY_RANDOM = 2;

  typedef logic [P*OW-1:0] pow_vec_t;

  logic      clk;
  logic      reset;
  sm_score_t in_data [P];
  logic      in_valid;
  logic      in_ready;
  sm_pow_t   out_values [P];
  sm_int_t   out_max;
  logic      out_valid;
  logic      out_ready;

  logic [31:0] stim_lfsr;
  logic [31:0] ready_lfsr;
  int          ready_mode;
  int          results_seen;
  sm_score_t   win_buf [P];
  sm_int_t     exp_max_q [$];
  pow_vec_t    exp_pow_q [$];

  // Monitor state for the stall stability check
  logic        holding;
  sm_int_t     held_max;
  sm_pow_t     held_values [P];

  softermax_local_window softermax_local_window_inst (
    .clk        (clk),
    .reset      (reset),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_values (out_values),
    .out_max    (out_max),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_run(input string what);
    $display("ERROR: %s", what);
    stop_run();
  endtask

  task automatic check_pow(input string name, input sm_pow_t got, input sm_pow_t want);
    if (got !== want) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
      stop_run();
    end
  endtask

  task automatic check_max(input string name, input sm_int_t got, input sm_int_t want);
    if (got !== want) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
      stop_run();
    end
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[30:0], stim_lfsr[0]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
    return bits;
  endfunction

  function automatic logic next_ready_bit();
    logic bit_out;
    bit_out = ready_lfsr[0];
    ready_lfsr = lfsr_next(ready_lfsr);
    return bit_out;
  endfunction

  // Floor of a Q4.4 score, in plain integer arithmetic
  function automatic int floor_int(input sm_score_t s);
    int v;
    v = int'(s);
    if (v >= 0) begin
      return v / 16;
    end
    return -((-v + 15) / 16);
  endfunction

  function automatic sm_int_t window_max();
    int m;
    m = floor_int(win_buf[0]);
    for (int i = 1; i < P; i++) begin
      if (floor_int(win_buf[i]) > m) begin
        m = floor_int(win_buf[i]);
      end
    end
    return sm_int_t'(m);
  endfunction

  // d = -n + f in sixteenths, result is (1 + f) * 128 / 2^n
  function automatic sm_pow_t pow2_approx(input sm_score_t s, input sm_int_t m);
    int d;
    int n;
    int r;
    d = int'(s) - 16 * int'(m);
    n = 0;
    while (d + 16 * n < 0) begin
      n++;
    end
    r = (16 + d + 16 * n) * 8;
    if (n >= 8) begin
      return '0;
    end
    return sm_pow_t'(r >> n);
  endfunction

  task automatic push_expected();
    sm_int_t  m;
    pow_vec_t pows;
    m = window_max();
    for (int i = 0; i < P; i++) begin
      pows[i*OW +: OW] = pow2_approx(win_buf[i], m);
    end
    exp_max_q.push_back(m);
    exp_pow_q.push_back(pows);
  endtask

  task automatic load_window(input sm_score_t a, input sm_score_t b,
                             input sm_score_t c, input sm_score_t d);
    win_buf[0] = a;
    win_buf[1] = b;
    win_buf[2] = c;
    win_buf[3] = d;
  endtask

  task automatic random_window();
    for (int i = 0; i < P; i++) begin
      win_buf[i] = sm_score_t'(take_bits(SW));
    end
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic send_window();
    int waited;
    waited = 0;
    in_data = win_buf;
    in_valid = 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_run("in_ready stayed low while a window was offered");
      end
      @(posedge clk);
    end
    push_expected();
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_max_q.size() != 0) begin
      if (waited >= WAIT_LIMIT) begin
        fail_run("expected results did not arrive before the timeout");
      end
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  task automatic compare_result();
    sm_int_t  want_max;
    pow_vec_t want_pows;
    if (exp_max_q.size() == 0) begin
      fail_run("output transfer with no window outstanding");
    end
    want_max = exp_max_q.pop_front();
    want_pows = exp_pow_q.pop_front();
    check_max("out_max", out_max, want_max);
    for (int i = 0; i < P; i++) begin
      check_pow($sformatf("out_values[%0d]", i), out_values[i], want_pows[i*OW +: OW]);
    end
    results_seen++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      holding = 1'b0;
    end else begin
      if (holding) begin
        if (!out_valid) begin
          fail_run("out_valid dropped while the output was stalled");
        end
        check_max("out_max held", out_max, held_max);
        for (int i = 0; i < P; i++) begin
          check_pow($sformatf("out_values[%0d] held", i), out_values[i], held_values[i]);
        end
      end
      if (out_valid && out_ready) begin
        compare_result();
      end
      holding = out_valid && !out_ready;
      held_max = out_max;
      held_values = out_values;
    end
  end

  // Sink side, changes 1 ns after the edge like the source
  always @(posedge clk) begin
    #1;
    if (ready_mode == READY_RANDOM) begin
      out_ready = next_ready_bit();
    end else begin
      out_ready = (ready_mode == READY_HIGH);
    end
  end

  task automatic test_single_window();
    // 2.1875, -1.5, 0.3125, -3.5625
    load_window(8'h23, 8'he8, 8'h05, 8'hc7);
    check_max("model max", window_max(), sm_int_t'(2));
    check_pow("model lane 0", pow2_approx(win_buf[0], sm_int_t'(2)), 8'h98);
    check_pow("model lane 1", pow2_approx(win_buf[1], sm_int_t'(2)), 8'h0c);
    check_pow("model lane 2", pow2_approx(win_buf[2], sm_int_t'(2)), 8'h2a);
    check_pow("model lane 3", pow2_approx(win_buf[3], sm_int_t'(2)), 8'h02);
    send_window();
    wait_drained();
  endtask

  task automatic test_corner_windows();
    load_window(8'h35, 8'h35, 8'h35, 8'h35);
    send_window();
    // Most positive against most negative, n reaches 15
    load_window(8'h7f, 8'h80, 8'h10, 8'h00);
    check_pow("model far lane", pow2_approx(win_buf[1], window_max()), 8'h00);
    send_window();
    // Max score 1.75 over integer max 1 gives 1.75
    load_window(8'h1c, 8'h0a, 8'hf3, 8'h12);
    check_pow("model top lane", pow2_approx(win_buf[0], window_max()), 8'he0);
    send_window();
    wait_drained();
  endtask

  task automatic test_burst();
    ready_mode = READY_HIGH;
    for (int k = 0; k < RANDOM_WINDOWS; k++) begin
      random_window();
      send_window();
    end
    wait_drained();
  endtask

  task automatic test_backpressure();
    ready_mode = READY_RANDOM;
    for (int k = 0; k < RANDOM_WINDOWS; k++) begin
      random_window();
      send_window();
    end
    ready_mode = READY_HIGH;
    wait_drained();
  endtask

  task automatic test_stall_drain();
    int sent;
    sent = 0;
    ready_mode = READY_LOW;
    while (in_ready && sent < STALL_LIMIT) begin
      random_window();
      send_window();
      sent++;
    end
    if (in_ready) begin
      fail_run("in_ready never dropped with out_ready held low");
    end
    ready_mode = READY_HIGH;
    wait_drained();
  endtask

  task automatic test_reset_midstream();
    ready_mode = READY_LOW;
    for (int k = 0; k < 6; k++) begin
      random_window();
      send_window();
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b1;
    exp_max_q.delete();
    exp_pow_q.delete();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    if (out_valid) begin
      fail_run("out_valid high right after reset");
    end
    if (!in_ready) begin
      fail_run("in_ready low right after reset");
    end
    ready_mode = READY_HIGH;
    load_window(8'hd8, 8'h44, 8'h3f, 8'hfe);
    send_window();
    wait_drained();
  endtask

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    out_ready = 1'b1;
    ready_mode = READY_HIGH;
    results_seen = 0;
    holding = 1'b0;
    stim_lfsr = SEED;
    ready_lfsr = SEED;
    for (int i = 0; i < P; i++) begin
      in_data[i] = '0;
      win_buf[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    test_single_window();
    test_corner_windows();
    test_burst();
    test_backpressure();
    test_stall_drain();
    test_reset_midstream();
    $display("Checked %0d results", results_seen);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- build.f
+incdir+rtl
rtl/softermax_pkg.sv
rtl/skid_buffer.sv
rtl/stream_fifo.sv
rtl/max_tree.sv
rtl/lpw_pow2.sv
rtl/softermax_local_window.sv
bench/softermax_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= softermax_tb
FILELIST  ?= build.f

.PHONY: sim clean

# Passes only when the simulation prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /Regression passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
